/* build.f */
common/riscv_pkg.sv
common/pipe_pkg.sv
common/es_ms_if.sv
common/data_sram_if.sv
ex/exu.sv
ex/lsu_store.sv
ex/ex_stage.sv
hdl/data_sram.sv
mem/ms_stage.sv
hdl/exe_mem_top.sv
testbench/exe_mem_assert.sv
testbench/tb_exe_mem_top.sv

/* testbench/tb_exe_mem_top.sv */
// table driven testbench for the execute and memory-access slice with a reference model
`timescale 1ns/1ps

module tb_exe_mem_top;

  typedef struct packed {
    riscv_pkg::gpr_data_t rs1;
    riscv_pkg::gpr_data_t rs2;
    riscv_pkg::gpr_data_t csrrdata;
    riscv_pkg::imm_t      imm;
    riscv_pkg::pc_t       pc;
    logic                 src1_sel;
    riscv_pkg::src2_sel_t src2_sel;
    logic                 word_cut;
    riscv_pkg::alu_op_t   alu_op;
    riscv_pkg::gpr_addr_t rd;
    riscv_pkg::csr_addr_t csr;
    logic                 gpr_wen;
    logic                 csr_wen;
    logic                 mem_ren;
    logic                 mem_wen;
    riscv_pkg::mem_op_t   mem_op;
    logic                 csr_inst_sel;
    riscv_pkg::csr_op_t   csr_op;
    logic                 lat_chk;    // exact two cycle latency expected
    riscv_pkg::gpr_data_t exp_result;
    riscv_pkg::gpr_data_t exp_csr_result;
  } entry_t;

  localparam int N_MAX = 300;

  logic                    i_clk;
  logic                    i_reset;
  logic                    i_ds_to_es_valid;
  pipe_pkg::ds_to_es_bus_t i_ds_to_es_bus;
  logic                    o_es_allowin;
  logic                    i_ws_allowin;
  logic                    o_ms_to_ws_valid;
  riscv_pkg::gpr_addr_t    o_ms_rd;
  logic                    o_ms_gpr_wen;
  riscv_pkg::gpr_data_t    o_ms_final_result;
  riscv_pkg::csr_addr_t    o_ms_csr;
  logic                    o_ms_csr_wen;
  riscv_pkg::gpr_data_t    o_ms_csr_result;

  entry_t      tab [N_MAX];
  logic [7:0]  mem_model [2048];  // byte image of the data sram
  int          n_tab = 0;
  int          n_steady = 0;
  int          cur_idx = 0;
  int          neg_cnt = 0;
  int          cyc_cnt = 0;
  int          timeout_lim = 0;
  int          exp_q[$];
  int          acc_q[$];
  logic        lat_mode = 1'b1;
  logic        stall_phase = 1'b0;
  integer      seed = 32'hc548;
  int          err_data = 0;
  int          err_rd = 0;
  int          err_csr = 0;
  int          err_other = 0;

  riscv_pkg::csr_op_t csr_ops [6] = '{riscv_pkg::CSR_RW, riscv_pkg::CSR_RS, riscv_pkg::CSR_RC,
                                      riscv_pkg::CSR_RWI, riscv_pkg::CSR_RSI, riscv_pkg::CSR_RCI};

  exe_mem_top #(
    .SRAM_DEPTH (256)
  ) i_exe_mem_top (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ds_to_es_valid  (i_ds_to_es_valid),
    .i_ds_to_es_bus    (i_ds_to_es_bus),
    .o_es_allowin      (o_es_allowin),
    .i_ws_allowin      (i_ws_allowin),
    .o_ms_to_ws_valid  (o_ms_to_ws_valid),
    .o_ms_rd           (o_ms_rd),
    .o_ms_gpr_wen      (o_ms_gpr_wen),
    .o_ms_final_result (o_ms_final_result),
    .o_ms_csr          (o_ms_csr),
    .o_ms_csr_wen      (o_ms_csr_wen),
    .o_ms_csr_result   (o_ms_csr_result)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[15:0]) % n;
  endfunction

  function automatic int mem_bytes(input riscv_pkg::mem_op_t op);
    case (op)
      riscv_pkg::MEM_B, riscv_pkg::MEM_BU: return 1;
      riscv_pkg::MEM_H, riscv_pkg::MEM_HU: return 2;
      riscv_pkg::MEM_W, riscv_pkg::MEM_WU: return 4;
      default:                             return 8;
    endcase
  endfunction

  function automatic pipe_pkg::ds_to_es_bus_t pack_bundle(input entry_t e);
    pipe_pkg::ds_to_es_bus_t b;
    b = '0;
    b[pipe_pkg::RS1_LSB +: 64]      = e.rs1;
    b[pipe_pkg::RS2_LSB +: 64]      = e.rs2;
    b[pipe_pkg::CSRRDATA_LSB +: 64] = e.csrrdata;
    b[pipe_pkg::IMM_LSB +: 64]      = e.imm;
    b[pipe_pkg::PC_LSB +: 64]       = e.pc;
    b[pipe_pkg::SRC1_SEL_BIT]       = e.src1_sel;
    b[pipe_pkg::SRC2_SEL_LSB +: 2]  = e.src2_sel;
    b[pipe_pkg::WORD_CUT_BIT]       = e.word_cut;
    b[pipe_pkg::ALU_OP_LSB +: 5]    = e.alu_op;
    b[pipe_pkg::RD_LSB +: 5]        = e.rd;
    b[pipe_pkg::CSR_LSB +: 12]      = e.csr;
    b[pipe_pkg::GPR_WEN_BIT]        = e.gpr_wen;
    b[pipe_pkg::CSR_WEN_BIT]        = e.csr_wen;
    b[pipe_pkg::MEM_REN_BIT]        = e.mem_ren;
    b[pipe_pkg::MEM_WEN_BIT]        = e.mem_wen;
    b[pipe_pkg::MEM_OP_LSB +: 3]    = e.mem_op;
    b[pipe_pkg::CSR_INST_SEL_BIT]   = e.csr_inst_sel;
    b[pipe_pkg::CSR_OP_LSB +: 3]    = e.csr_op;
    return b;
  endfunction

  function automatic riscv_pkg::gpr_data_t ref_alu(input entry_t e);
    riscv_pkg::gpr_data_t a;
    riscv_pkg::gpr_data_t b;
    riscv_pkg::gpr_data_t r;
    logic [31:0]          w;
    a = e.src1_sel ? e.pc : e.rs1;
    case (e.src2_sel)
      riscv_pkg::SRC2_IMM:  b = e.imm;
      riscv_pkg::SRC2_FOUR: b = 64'd4;
      default:              b = e.rs2;
    endcase
    case (e.alu_op)
      riscv_pkg::ALU_ADD:   r = a + b;
      riscv_pkg::ALU_SUB:   r = a - b;
      riscv_pkg::ALU_SLL:   r = a << b[5:0];
      riscv_pkg::ALU_SLT:   r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      riscv_pkg::ALU_SLTU:  r = (a < b) ? 64'd1 : 64'd0;
      riscv_pkg::ALU_XOR:   r = a ^ b;
      riscv_pkg::ALU_SRL:   r = a >> b[5:0];
      riscv_pkg::ALU_SRA:   r = $signed(a) >>> b[5:0];
      riscv_pkg::ALU_OR:    r = a | b;
      riscv_pkg::ALU_AND:   r = a & b;
      riscv_pkg::ALU_PASS2: r = b;
      default:              r = 64'd0;
    endcase
    if (e.word_cut) begin
      case (e.alu_op)
        riscv_pkg::ALU_SLL: w = a[31:0] << b[4:0];
        riscv_pkg::ALU_SRL: w = a[31:0] >> b[4:0];
        riscv_pkg::ALU_SRA: w = $signed(a[31:0]) >>> b[4:0];
        default:            w = r[31:0];  // add/sub low half is exact
      endcase
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  function automatic riscv_pkg::gpr_data_t ref_csr(input entry_t e);
    riscv_pkg::gpr_data_t src;
    if (e.csr_op == riscv_pkg::CSR_RWI || e.csr_op == riscv_pkg::CSR_RSI ||
        e.csr_op == riscv_pkg::CSR_RCI) begin
      src = e.imm;
    end else begin
      src = e.rs1;
    end
    case (e.csr_op)
      riscv_pkg::CSR_RW, riscv_pkg::CSR_RWI: return src;
      riscv_pkg::CSR_RS, riscv_pkg::CSR_RSI: return e.csrrdata | src;
      riscv_pkg::CSR_RC, riscv_pkg::CSR_RCI: return e.csrrdata & ~src;
      default:                               return e.csrrdata;
    endcase
  endfunction

  function automatic riscv_pkg::gpr_data_t model_load(input riscv_pkg::mem_op_t op, input int a);
    riscv_pkg::gpr_data_t v;
    v = '0;
    for (int i = 0; i < mem_bytes(op); i++) v[8*i +: 8] = mem_model[a+i];
    case (op)
      riscv_pkg::MEM_B: v = {{56{v[7]}}, v[7:0]};
      riscv_pkg::MEM_H: v = {{48{v[15]}}, v[15:0]};
      riscv_pkg::MEM_W: v = {{32{v[31]}}, v[31:0]};
      default:          v = v;  // unsigned forms already zero filled
    endcase
    return v;
  endfunction

  function automatic entry_t new_entry();
    entry_t      e;
    logic [31:0] r;
    e = '0;
    r = $random(seed);
    e.rs1 = rand64();
    e.rs2 = rand64();
    e.csrrdata = rand64();
    e.imm = rand64();
    e.pc = rand64();
    e.rd = r[4:0];
    e.csr = r[27:16];
    e.gpr_wen = 1'b1;
    return e;
  endfunction

  // expected values with the memory model updated in program order
  task automatic add_entry(input entry_t e);
    riscv_pkg::gpr_data_t alu;
    int                   a;
    e.lat_chk = lat_mode;
    alu = ref_alu(e);
    a = int'(alu[10:0]);
    e.exp_csr_result = ref_csr(e);
    if (e.mem_wen) begin
      for (int i = 0; i < mem_bytes(e.mem_op); i++) mem_model[a+i] = e.rs2[8*i +: 8];
    end
    if (e.mem_ren) e.exp_result = model_load(e.mem_op, a);
    else if (e.csr_inst_sel) e.exp_result = e.csrrdata;
    else e.exp_result = alu;
    tab[n_tab] = e;
    n_tab++;
  endtask

  task automatic add_alu(input riscv_pkg::alu_op_t op, input logic s1,
                         input riscv_pkg::src2_sel_t s2, input logic wc);
    entry_t e;
    e = new_entry();
    e.alu_op = op;
    e.src1_sel = s1;
    e.src2_sel = s2;
    e.word_cut = wc;
    add_entry(e);
  endtask

  task automatic add_mem(input logic wr, input riscv_pkg::mem_op_t op, input int addr);
    entry_t e;
    e = new_entry();
    e.src2_sel = riscv_pkg::SRC2_IMM;
    e.alu_op = riscv_pkg::ALU_ADD;
    e.rs1 = 64'(addr) + 64'd64;
    e.imm = 64'hffff_ffff_ffff_ffc0;  // -64
    e.mem_op = op;
    e.mem_wen = wr;
    e.mem_ren = !wr;
    e.gpr_wen = !wr;
    add_entry(e);
  endtask

  task automatic build_table();
    entry_t e;
    int     dw;
    int     nb;
    int     op;
    for (int o = 0; o < 11; o++)
      for (int s1 = 0; s1 < 2; s1++)
        for (int s2 = 0; s2 < 3; s2++) add_alu(5'(o), 1'(s1), 2'(s2), 1'b0);
    repeat (2) begin
      add_alu(riscv_pkg::ALU_ADD, 1'b0, riscv_pkg::SRC2_RS2, 1'b1);
      add_alu(riscv_pkg::ALU_SUB, 1'b0, riscv_pkg::SRC2_RS2, 1'b1);
      add_alu(riscv_pkg::ALU_SLL, 1'b0, riscv_pkg::SRC2_RS2, 1'b1);
      add_alu(riscv_pkg::ALU_SRL, 1'b0, riscv_pkg::SRC2_IMM, 1'b1);
      add_alu(riscv_pkg::ALU_SRA, 1'b0, riscv_pkg::SRC2_RS2, 1'b1);
    end
    for (int i = 0; i < 12; i++) begin
      e = new_entry();
      e.csr_op = csr_ops[i % 6];
      e.csr_wen = 1'b1;
      e.csr_inst_sel = 1'b1;
      if (i % 6 >= 3) e.imm = {59'b0, e.imm[4:0]};  // zimm
      add_entry(e);
    end
    dw = 0;
    for (int sz = 0; sz < 4; sz++) begin
      nb = 1 << sz;
      for (int off = 0; off < 8; off += nb) begin
        dw++;
        add_mem(1'b1, 3'(sz), dw * 8 + off);
        for (int lop = 0; lop < 7; lop++) begin
          add_mem(1'b0, 3'(lop), dw * 8 + (off / mem_bytes(3'(lop))) * mem_bytes(3'(lop)));
        end
      end
    end
    n_steady = n_tab;
    lat_mode = 1'b0;
    for (int i = 0; i < 60; i++) begin
      case (i % 3)
        0: begin
          op = rand_below(4);
          nb = mem_bytes(3'(op));
          add_mem(1'b1, 3'(op), rand_below(16) * 8 + rand_below(8 / nb) * nb);
        end
        1: begin
          op = rand_below(7);
          nb = mem_bytes(3'(op));
          add_mem(1'b0, 3'(op), rand_below(16) * 8 + rand_below(8 / nb) * nb);
        end
        default: add_alu(5'(rand_below(11)), 1'(rand_below(2)), 2'(rand_below(3)), 1'b0);
      endcase
    end
  endtask

  task automatic check_data(input int k, input string name, input riscv_pkg::gpr_data_t got,
                            input riscv_pkg::gpr_data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: entry %0d %s got %h expected %h", $time, k, name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_rd(input int k, input riscv_pkg::gpr_addr_t got,
                          input riscv_pkg::gpr_addr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: entry %0d rd got %0d expected %0d", $time, k, got, exp);
      err_rd++;
    end
  endtask

  task automatic check_csr(input int k, input riscv_pkg::csr_addr_t got,
                           input riscv_pkg::csr_addr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: entry %0d csr got %h expected %h", $time, k, got, exp);
      err_csr++;
    end
  endtask

  task automatic check_flag(input int k, input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: entry %0d %s got %b expected %b", $time, k, name, got, exp);
      err_other++;
    end
  endtask

  // scoreboard sampled mid cycle
  always @(negedge i_clk) begin : monitor
    int k;
    int acc;
    neg_cnt++;
    if (!i_reset && o_ms_to_ws_valid && i_ws_allowin) begin
      if (exp_q.size() == 0) begin
        $display("result at %0t with nothing in flight", $time);
        err_other++;
      end else begin
        k = exp_q.pop_front();
        acc = acc_q.pop_front();
        check_rd(k, o_ms_rd, tab[k].rd);
        check_flag(k, "gpr_wen", o_ms_gpr_wen, tab[k].gpr_wen);
        check_data(k, "final_result", o_ms_final_result, tab[k].exp_result);
        check_flag(k, "csr_wen", o_ms_csr_wen, tab[k].csr_wen);
        if (tab[k].csr_wen) begin
          check_csr(k, o_ms_csr, tab[k].csr);
          check_data(k, "csr_result", o_ms_csr_result, tab[k].exp_csr_result);
        end
        if (tab[k].lat_chk && neg_cnt - acc != 2) begin
          $display("entry %0d left %0d cycles after its accept, not 2", k, neg_cnt - acc);
          err_other++;
        end
      end
    end
    if (!i_reset && i_ds_to_es_valid && o_es_allowin) begin
      exp_q.push_back(cur_idx);
      acc_q.push_back(neg_cnt);
    end
  end

  always @(posedge i_clk) begin : allowin_drive
    logic [31:0] r;
    #1;
    if (stall_phase) begin
      r = $random(seed);
      i_ws_allowin = r[0];
    end else begin
      i_ws_allowin = 1'b1;
    end
  end

  always @(posedge i_clk) begin
    cyc_cnt++;
    if (cyc_cnt > timeout_lim) begin
      $display("timeout after %0d cycles, %0d results never arrived", cyc_cnt, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic apply_entry(input int k);
    cur_idx = k;
    i_ds_to_es_bus = pack_bundle(tab[k]);
    i_ds_to_es_valid = 1'b1;
    @(negedge i_clk);
    while (!o_es_allowin) @(negedge i_clk);
    @(posedge i_clk);
    #1;
  endtask

  task automatic wait_drain();
    i_ds_to_es_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge i_clk);
    @(posedge i_clk);
    #1;
  endtask

  initial begin
    i_reset = 1'b1;
    i_ds_to_es_valid = 1'b0;
    i_ds_to_es_bus = '0;
    i_ws_allowin = 1'b1;
    for (int i = 0; i < 2048; i++) mem_model[i] = 8'h00;
    build_table();
    timeout_lim = 4 * n_tab + 100;
    repeat (8) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    @(negedge i_clk);
    if (o_es_allowin !== 1'b1 || o_ms_to_ws_valid !== 1'b0) begin
      $display("pipeline not empty and ready after reset");
      err_other++;
    end
    @(posedge i_clk);
    #1;
    for (int k = 0; k < n_steady; k++) apply_entry(k);
    wait_drain();
    stall_phase = 1'b1;
    for (int k = n_steady; k < n_tab; k++) apply_entry(k);
    wait_drain();
    stall_phase = 1'b0;
    repeat (4) @(posedge i_clk);
    $display("errors: data %0d rd %0d csr %0d other %0d", err_data, err_rd, err_csr, err_other);
    if (err_data + err_rd + err_csr + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* testbench/exe_mem_assert.sv */
// handshake and reset assertions bound onto the slice top level
`timescale 1ns/1ps

module exe_mem_assert (
  input logic                 i_clk,
  input logic                 i_reset,
  input logic                 i_ws_allowin,
  input logic                 i_valid,
  input riscv_pkg::gpr_addr_t i_rd,
  input riscv_pkg::gpr_data_t i_final_result,
  input riscv_pkg::csr_addr_t i_csr,
  input riscv_pkg::gpr_data_t i_csr_result,
  input logic                 i_sram_ren,
  input logic                 i_sram_wen
);

  // nothing leaves right after reset
  reset_empty: assert property (@(posedge i_clk) i_reset |=> !i_valid)
    else $error("valid output in the cycle after reset");

  stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_valid && !i_ws_allowin) |=> (i_valid && $stable(i_rd) && $stable(i_final_result) &&
                                    $stable(i_csr) && $stable(i_csr_result)))
    else $error("outputs changed while stalled by writeback");

  strobe_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_sram_ren && i_sram_wen))
    else $error("sram read and write strobes high together");

endmodule

bind exe_mem_top exe_mem_assert u_exe_mem_assert (
  .i_clk          (i_clk),
  .i_reset        (i_reset),
  .i_ws_allowin   (i_ws_allowin),
  .i_valid        (o_ms_to_ws_valid),
  .i_rd           (o_ms_rd),
  .i_final_result (o_ms_final_result),
  .i_csr          (o_ms_csr),
  .i_csr_result   (o_ms_csr_result),
  .i_sram_ren     (u_data_sram_if.ren),
  .i_sram_wen     (u_data_sram_if.wen)
);

/* hdl/exe_mem_top.sv */
// execute and memory-access slice top: both stages plus the data sram
`timescale 1ns/1ps

module exe_mem_top #(
  parameter int SRAM_DEPTH = 256
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_ds_to_es_valid,
  input  pipe_pkg::ds_to_es_bus_t i_ds_to_es_bus,
  output logic                    o_es_allowin,
  input  logic                    i_ws_allowin,
  output logic                    o_ms_to_ws_valid,
  output riscv_pkg::gpr_addr_t    o_ms_rd,
  output logic                    o_ms_gpr_wen,
  output riscv_pkg::gpr_data_t    o_ms_final_result,
  output riscv_pkg::csr_addr_t    o_ms_csr,
  output logic                    o_ms_csr_wen,
  output riscv_pkg::gpr_data_t    o_ms_csr_result
);

  es_ms_if     u_es_ms_if ();
  data_sram_if u_data_sram_if ();

  ex_stage u_ex_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .o_es_allowin     (o_es_allowin),
    .es2ms            (u_es_ms_if.es),
    .sram             (u_data_sram_if.master)
  );

  data_sram #(
    .SRAM_DEPTH (SRAM_DEPTH)
  ) u_data_sram (
    .i_clk (i_clk),
    .sram  (u_data_sram_if.slave)
  );

  ms_stage u_ms_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .es2ms             (u_es_ms_if.ms),
    .sram              (u_data_sram_if.sink),
    .i_ws_allowin      (i_ws_allowin),
    .o_ms_to_ws_valid  (o_ms_to_ws_valid),
    .o_ms_rd           (o_ms_rd),
    .o_ms_gpr_wen      (o_ms_gpr_wen),
    .o_ms_final_result (o_ms_final_result),
    .o_ms_csr          (o_ms_csr),
    .o_ms_csr_wen      (o_ms_csr_wen),
    .o_ms_csr_result   (o_ms_csr_result)
  );

endmodule

/* mem/ms_stage.sv */
// memory stage: transfer register, read data hold, load extension, result select
`timescale 1ns/1ps

module ms_stage (
  input  logic                 i_clk,
  input  logic                 i_reset,
  es_ms_if.ms                  es2ms,
  data_sram_if.sink            sram,
  input  logic                 i_ws_allowin,
  output logic                 o_ms_to_ws_valid,
  output riscv_pkg::gpr_addr_t o_ms_rd,
  output logic                 o_ms_gpr_wen,
  output riscv_pkg::gpr_data_t o_ms_final_result,
  output riscv_pkg::csr_addr_t o_ms_csr,
  output logic                 o_ms_csr_wen,
  output riscv_pkg::gpr_data_t o_ms_csr_result
);

  logic                 ms_valid;
  logic                 ms_ready_go;
  logic                 ms_accept;
  logic                 ms_first;     // first cycle holding this instruction
  logic                 ms_mem_ren;
  riscv_pkg::mem_op_t   ms_mem_op;
  logic                 ms_csr_inst_sel;
  riscv_pkg::gpr_data_t ms_csrrdata;
  riscv_pkg::gpr_data_t ms_alu_result;
  riscv_pkg::gpr_data_t rdata_hold;
  riscv_pkg::gpr_data_t rdata;
  riscv_pkg::gpr_data_t rdata_shift;
  riscv_pkg::gpr_data_t load_result;

  assign ms_ready_go      = 1'b1;
  assign es2ms.ms_allowin = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign ms_accept        = es2ms.es_to_ms_valid && es2ms.ms_allowin;
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
      ms_first <= 1'b0;
    end else begin
      if (es2ms.ms_allowin) ms_valid <= es2ms.es_to_ms_valid;
      ms_first <= ms_accept;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_accept) begin
      o_ms_rd         <= es2ms.rd;
      o_ms_csr        <= es2ms.csr;
      o_ms_gpr_wen    <= es2ms.gpr_wen;
      o_ms_csr_wen    <= es2ms.csr_wen;
      ms_mem_ren      <= es2ms.mem_ren;
      ms_mem_op       <= es2ms.mem_op;
      ms_csr_inst_sel <= es2ms.csr_inst_sel;
      ms_csrrdata     <= es2ms.csrrdata;
      ms_alu_result   <= es2ms.alu_result;
      o_ms_csr_result <= es2ms.csr_result;
    end
    if (ms_first && ms_mem_ren) begin
      rdata_hold <= sram.rdata;
    end
  end

  // live sram data in the first cycle, held copy under a stall
  assign rdata       = ms_first ? sram.rdata : rdata_hold;
  assign rdata_shift = rdata >> {ms_alu_result[2:0], 3'b000};

  always_comb begin
    case (ms_mem_op)
      riscv_pkg::MEM_B:  load_result = {{56{rdata_shift[7]}}, rdata_shift[7:0]};
      riscv_pkg::MEM_H:  load_result = {{48{rdata_shift[15]}}, rdata_shift[15:0]};
      riscv_pkg::MEM_W:  load_result = {{32{rdata_shift[31]}}, rdata_shift[31:0]};
      riscv_pkg::MEM_BU: load_result = {56'b0, rdata_shift[7:0]};
      riscv_pkg::MEM_HU: load_result = {48'b0, rdata_shift[15:0]};
      riscv_pkg::MEM_WU: load_result = {32'b0, rdata_shift[31:0]};
      default:           load_result = rdata_shift;  // doubleword
    endcase
  end

  always_comb begin
    if (ms_mem_ren) begin
      o_ms_final_result = load_result;
    end else if (ms_csr_inst_sel) begin
      o_ms_final_result = ms_csrrdata;  // old csr value goes to rd
    end else begin
      o_ms_final_result = ms_alu_result;
    end
  end

endmodule

/* hdl/data_sram.sv */
// data sram: byte-writable 64-bit words, registered read data
`timescale 1ns/1ps

module data_sram #(
  parameter int SRAM_DEPTH = 256
) (
  input  logic       i_clk,
  data_sram_if.slave sram
);

  localparam int IDX_WD = $clog2(SRAM_DEPTH);

  riscv_pkg::gpr_data_t mem [SRAM_DEPTH];
  logic [IDX_WD-1:0]    idx;

  assign idx = sram.addr[IDX_WD+2:3];  // word index above the byte offset

  initial begin
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (sram.wen) begin
      for (int b = 0; b < 8; b++) begin
        if (sram.wmask[b]) mem[idx][8*b +: 8] <= sram.wdata[8*b +: 8];
      end
    end
    if (sram.ren) begin
      sram.rdata <= mem[idx];  // holds between reads
    end
  end

endmodule

/* ex/ex_stage.sv */
// execute stage: bundle register, handshake, alu/csr compute and sram request
`timescale 1ns/1ps

module ex_stage (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_ds_to_es_valid,
  input  pipe_pkg::ds_to_es_bus_t i_ds_to_es_bus,
  output logic                    o_es_allowin,
  es_ms_if.es                     es2ms,
  data_sram_if.master             sram
);

  logic                    es_valid;
  logic                    es_ready_go;
  logic                    es_go;
  pipe_pkg::ds_to_es_bus_t ds_to_es_bus_r;

  riscv_pkg::gpr_data_t    es_rs1data;
  riscv_pkg::gpr_data_t    es_rs2data;
  riscv_pkg::gpr_data_t    es_csrrdata;
  riscv_pkg::imm_t         es_imm;
  riscv_pkg::pc_t          es_pc;
  riscv_pkg::gpr_data_t    es_alu_result;
  riscv_pkg::mem_op_t      es_mem_op;

  assign es_ready_go  = 1'b1;
  assign o_es_allowin = !es_valid || (es_ready_go && es2ms.ms_allowin);
  assign es_go        = es_valid && es_ready_go && es2ms.ms_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      ds_to_es_bus_r <= i_ds_to_es_bus;
    end
  end

  // operands
  assign es_rs1data  = ds_to_es_bus_r[pipe_pkg::RS1_LSB      +: pipe_pkg::XLEN];
  assign es_rs2data  = ds_to_es_bus_r[pipe_pkg::RS2_LSB      +: pipe_pkg::XLEN];
  assign es_csrrdata = ds_to_es_bus_r[pipe_pkg::CSRRDATA_LSB +: pipe_pkg::XLEN];
  assign es_imm      = ds_to_es_bus_r[pipe_pkg::IMM_LSB      +: pipe_pkg::XLEN];
  assign es_pc       = ds_to_es_bus_r[pipe_pkg::PC_LSB       +: pipe_pkg::XLEN];
  assign es_mem_op   = ds_to_es_bus_r[pipe_pkg::MEM_OP_LSB   +: 3];

  assign es2ms.es_to_ms_valid = es_valid && es_ready_go;
  assign es2ms.rd             = ds_to_es_bus_r[pipe_pkg::RD_LSB +: 5];
  assign es2ms.csr            = ds_to_es_bus_r[pipe_pkg::CSR_LSB +: 12];
  assign es2ms.gpr_wen        = ds_to_es_bus_r[pipe_pkg::GPR_WEN_BIT];
  assign es2ms.csr_wen        = ds_to_es_bus_r[pipe_pkg::CSR_WEN_BIT];
  assign es2ms.mem_ren        = ds_to_es_bus_r[pipe_pkg::MEM_REN_BIT];
  assign es2ms.mem_op         = es_mem_op;
  assign es2ms.csr_inst_sel   = ds_to_es_bus_r[pipe_pkg::CSR_INST_SEL_BIT];
  assign es2ms.csrrdata       = es_csrrdata;
  assign es2ms.alu_result     = es_alu_result;

  exu u_exu (
    .i_rs1data          (es_rs1data),
    .i_rs2data          (es_rs2data),
    .i_imm              (es_imm),
    .i_pc               (es_pc),
    .i_csrrdata         (es_csrrdata),
    .i_alu_src1_sel     (ds_to_es_bus_r[pipe_pkg::SRC1_SEL_BIT]),
    .i_alu_src2_sel     (ds_to_es_bus_r[pipe_pkg::SRC2_SEL_LSB +: 2]),
    .i_alu_op           (ds_to_es_bus_r[pipe_pkg::ALU_OP_LSB +: 5]),
    .i_alu_word_cut_sel (ds_to_es_bus_r[pipe_pkg::WORD_CUT_BIT]),
    .i_csr_op           (ds_to_es_bus_r[pipe_pkg::CSR_OP_LSB +: 3]),
    .o_alu_result       (es_alu_result),
    .o_csr_result       (es2ms.csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op      (es_mem_op),
    .i_waddr_align (es_alu_result[2:0]),  // rs1 + imm
    .i_wdata       (es_rs2data),
    .o_wmask       (sram.wmask),
    .o_wdata       (sram.wdata)
  );

  // strobes only on the move, so a stall never repeats them
  assign sram.ren  = ds_to_es_bus_r[pipe_pkg::MEM_REN_BIT] && es_go;
  assign sram.wen  = ds_to_es_bus_r[pipe_pkg::MEM_WEN_BIT] && es_go;
  assign sram.addr = es_alu_result[31:0];

endmodule

/* ex/lsu_store.sv */
// store alignment: byte enables and shifted write data for the access size
`timescale 1ns/1ps

module lsu_store (
  input  riscv_pkg::mem_op_t    i_mem_op,
  input  logic [2:0]            i_waddr_align,
  input  riscv_pkg::gpr_data_t  i_wdata,
  output pipe_pkg::sram_wmask_t o_wmask,
  output riscv_pkg::gpr_data_t  o_wdata
);

  pipe_pkg::sram_wmask_t size_mask;

  always_comb begin
    case (i_mem_op)
      riscv_pkg::MEM_B: size_mask = 8'h01;
      riscv_pkg::MEM_H: size_mask = 8'h03;
      riscv_pkg::MEM_W: size_mask = 8'h0f;
      riscv_pkg::MEM_D: size_mask = 8'hff;
      default:          size_mask = 8'h00;  // unsigned codes are loads only
    endcase
  end

  assign o_wmask = size_mask << i_waddr_align;
  assign o_wdata = i_wdata << {i_waddr_align, 3'b000};  // 8 * offset

endmodule

/* ex/exu.sv */
// execute unit doing operand muxing, the 64-bit alu with word truncation and the csr update value
`timescale 1ns/1ps

module exu (
  input  riscv_pkg::gpr_data_t i_rs1data,
  input  riscv_pkg::gpr_data_t i_rs2data,
  input  riscv_pkg::imm_t      i_imm,
  input  riscv_pkg::pc_t       i_pc,
  input  riscv_pkg::gpr_data_t i_csrrdata,
  input  logic                 i_alu_src1_sel,   // 1 selects pc
  input  riscv_pkg::src2_sel_t i_alu_src2_sel,
  input  riscv_pkg::alu_op_t   i_alu_op,
  input  logic                 i_alu_word_cut_sel,
  input  riscv_pkg::csr_op_t   i_csr_op,
  output riscv_pkg::gpr_data_t o_alu_result,
  output riscv_pkg::gpr_data_t o_csr_result
);

  riscv_pkg::gpr_data_t src1;
  riscv_pkg::gpr_data_t src2;
  riscv_pkg::gpr_data_t alu_raw;
  riscv_pkg::gpr_data_t srl_res;
  riscv_pkg::gpr_data_t sra_res;
  riscv_pkg::gpr_data_t csr_src;
  logic [5:0]           shamt;
  logic [31:0]          srl_w;
  logic [31:0]          sra_w;

  assign src1 = i_alu_src1_sel ? i_pc : i_rs1data;

  always_comb begin
    case (i_alu_src2_sel)
      riscv_pkg::SRC2_IMM:  src2 = i_imm;
      riscv_pkg::SRC2_FOUR: src2 = 64'd4;
      default:              src2 = i_rs2data;
    endcase
  end

  // word ops shift by 5 bits only
  assign shamt = i_alu_word_cut_sel ? {1'b0, src2[4:0]} : src2[5:0];

  assign srl_w   = src1[31:0] >> shamt[4:0];
  assign sra_w   = $signed(src1[31:0]) >>> shamt[4:0];
  assign srl_res = i_alu_word_cut_sel ? {32'b0, srl_w} : (src1 >> shamt);
  assign sra_res = i_alu_word_cut_sel ? $signed({32'b0, sra_w}) : ($signed(src1) >>> shamt);

  always_comb begin
    case (i_alu_op)
      riscv_pkg::ALU_ADD:   alu_raw = src1 + src2;
      riscv_pkg::ALU_SUB:   alu_raw = src1 - src2;
      riscv_pkg::ALU_SLL:   alu_raw = src1 << shamt;
      riscv_pkg::ALU_SLT:   alu_raw = {63'b0, $signed(src1) < $signed(src2)};
      riscv_pkg::ALU_SLTU:  alu_raw = {63'b0, src1 < src2};
      riscv_pkg::ALU_XOR:   alu_raw = src1 ^ src2;
      riscv_pkg::ALU_SRL:   alu_raw = srl_res;
      riscv_pkg::ALU_SRA:   alu_raw = sra_res;
      riscv_pkg::ALU_OR:    alu_raw = src1 | src2;
      riscv_pkg::ALU_AND:   alu_raw = src1 & src2;
      riscv_pkg::ALU_PASS2: alu_raw = src2;
      default:              alu_raw = 64'b0;
    endcase
  end

  assign o_alu_result = i_alu_word_cut_sel ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // immediate forms take zimm from the imm field
  assign csr_src = i_csr_op[2] ? i_imm : i_rs1data;

  always_comb begin
    case (i_csr_op)
      riscv_pkg::CSR_RW,
      riscv_pkg::CSR_RWI: o_csr_result = csr_src;
      riscv_pkg::CSR_RS,
      riscv_pkg::CSR_RSI: o_csr_result = i_csrrdata | csr_src;
      riscv_pkg::CSR_RC,
      riscv_pkg::CSR_RCI: o_csr_result = i_csrrdata & ~csr_src;
      default:            o_csr_result = i_csrrdata;  // no csr op keeps the old value
    endcase
  end

endmodule

/* common/data_sram_if.sv */
// data sram request from execute, read data back to memory stage
`timescale 1ns/1ps

interface data_sram_if;

  pipe_pkg::sram_addr_t  addr;
  logic                  ren;    // single cycle strobes
  logic                  wen;
  pipe_pkg::sram_wmask_t wmask;
  riscv_pkg::gpr_data_t  wdata;
  riscv_pkg::gpr_data_t  rdata;  // valid the cycle after ren

  modport master (output addr, ren, wen, wmask, wdata);

  modport slave (input addr, ren, wen, wmask, wdata, output rdata);

  modport sink (input rdata);

endinterface

/* common/es_ms_if.sv */
// execute to memory stage transfer, valid/allowin plus forwarded fields
`timescale 1ns/1ps

interface es_ms_if;

  logic                  es_to_ms_valid;
  logic                  ms_allowin;
  riscv_pkg::gpr_addr_t  rd;
  riscv_pkg::csr_addr_t  csr;
  logic                  gpr_wen;
  logic                  csr_wen;
  logic                  mem_ren;
  riscv_pkg::mem_op_t    mem_op;
  logic                  csr_inst_sel;
  riscv_pkg::gpr_data_t  csrrdata;
  riscv_pkg::gpr_data_t  alu_result;   // also carries the load address
  riscv_pkg::gpr_data_t  csr_result;

  modport es (
    output es_to_ms_valid, rd, csr, gpr_wen, csr_wen, mem_ren, mem_op,
    output csr_inst_sel, csrrdata, alu_result, csr_result,
    input  ms_allowin
  );

  modport ms (
    input  es_to_ms_valid, rd, csr, gpr_wen, csr_wen, mem_ren, mem_op,
    input  csr_inst_sel, csrrdata, alu_result, csr_result,
    output ms_allowin
  );

endinterface

/* common/pipe_pkg.sv */
// pipeline package: decode-to-execute bundle layout and sram request types
package pipe_pkg;

  // field positions, low end first
  localparam int CSR_OP_LSB       = 0;    // 3 bits
  localparam int CSR_INST_SEL_BIT = 3;
  localparam int MEM_OP_LSB       = 4;    // 3 bits
  localparam int MEM_WEN_BIT      = 7;
  localparam int MEM_REN_BIT      = 8;
  localparam int CSR_WEN_BIT      = 9;
  localparam int GPR_WEN_BIT      = 10;
  localparam int CSR_LSB          = 11;   // 12 bits
  localparam int RD_LSB           = 23;   // 5 bits
  localparam int ALU_OP_LSB       = 28;   // 5 bits
  localparam int WORD_CUT_BIT     = 33;
  localparam int SRC2_SEL_LSB     = 34;   // 2 bits
  localparam int SRC1_SEL_BIT     = 36;
  localparam int PC_LSB           = 37;   // 64 bits each from here up
  localparam int IMM_LSB          = 101;
  localparam int CSRRDATA_LSB     = 165;
  localparam int RS2_LSB          = 229;
  localparam int RS1_LSB          = 293;

  localparam int XLEN             = 64;
  localparam int DS_TO_ES_BUS_WD  = RS1_LSB + XLEN;

  typedef logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus_t;

  typedef logic [31:0] sram_addr_t;
  typedef logic [7:0]  sram_wmask_t;

endpackage

/* common/riscv_pkg.sv */
// riscv isa package: data widths and operation codes used by the execute slice
package riscv_pkg;

  typedef logic [63:0] gpr_data_t;
  typedef logic [63:0] pc_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [63:0] imm_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [2:0]  csr_op_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [1:0]  src2_sel_t;

  localparam alu_op_t ALU_ADD   = 5'd0;
  localparam alu_op_t ALU_SUB   = 5'd1;
  localparam alu_op_t ALU_SLL   = 5'd2;
  localparam alu_op_t ALU_SLT   = 5'd3;
  localparam alu_op_t ALU_SLTU  = 5'd4;
  localparam alu_op_t ALU_XOR   = 5'd5;
  localparam alu_op_t ALU_SRL   = 5'd6;
  localparam alu_op_t ALU_SRA   = 5'd7;
  localparam alu_op_t ALU_OR    = 5'd8;
  localparam alu_op_t ALU_AND   = 5'd9;
  localparam alu_op_t ALU_PASS2 = 5'd10;  // lui

  // funct3 style encoding, bit 2 marks the immediate forms
  localparam csr_op_t CSR_RW  = 3'd1;
  localparam csr_op_t CSR_RS  = 3'd2;
  localparam csr_op_t CSR_RC  = 3'd3;
  localparam csr_op_t CSR_RWI = 3'd5;
  localparam csr_op_t CSR_RSI = 3'd6;
  localparam csr_op_t CSR_RCI = 3'd7;

  localparam mem_op_t MEM_B  = 3'd0;
  localparam mem_op_t MEM_H  = 3'd1;
  localparam mem_op_t MEM_W  = 3'd2;
  localparam mem_op_t MEM_D  = 3'd3;
  localparam mem_op_t MEM_BU = 3'd4;
  localparam mem_op_t MEM_HU = 3'd5;
  localparam mem_op_t MEM_WU = 3'd6;

  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2;

endpackage
